// ==== Bender.yml ====
package:
  name: mips_pipeline

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpu_pkg.sv
      - hdl/register_file.sv
      - hdl/decode_unit.sv
      - hdl/alu.sv
      - hdl/stage_latch.sv
      - hdl/datapath.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/datapath_checker.sv
      - dv/datapath_tb.sv

// ==== dv/datapath_checker.sv ====
// ----------------------------
// store checker, runs the program on an ISA
// model and compares every completed store
// ----------------------------

`default_nettype none

`include "cpu_macros.svh"

module datapath_checker (
	input  logic                   CLK,
	input  logic                   arst_n,
	input  logic [`CPU_WORD_W-1:0] imemaddr,
	input  logic                   imemren,
	input  logic [`CPU_WORD_W-1:0] dmemaddr,
	input  logic [`CPU_WORD_W-1:0] dmemstore,
	input  logic                   dmemren,
	input  logic                   dmemwen,
	input  logic                   dhit,
	input  logic                   halt,
	output int                     check_cnt,
	output int                     error_cnt
);

	logic [`CPU_WORD_W-1:0] exp_addr [$];
	logic [`CPU_WORD_W-1:0] exp_data [$];
	int                     store_idx;
	bit                     armed;
	bit                     halt_seen;

	// one instruction at a time, no pipeline
	function automatic void run_reference();
		logic [31:0] regs [32];
		logic [31:0] mem [256];
		logic [31:0] ins;
		logic [31:0] rs_v;
		logic [31:0] rt_v;
		logic [31:0] sext;
		logic [31:0] zext;
		logic [31:0] addr;
		logic [4:0]  rd;
		logic [4:0]  rt;
		int          pc;
		bit          done;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			mem[i] = '0;
		end
		exp_addr.delete();
		exp_data.delete();
		pc   = 0;
		done = 1'b0;
		while (!done && pc < datapath_tb.prog_len) begin
			ins  = datapath_tb.prog[pc];
			rs_v = regs[ins[25:21]];
			rt_v = regs[ins[20:16]];
			sext = {{16{ins[15]}}, ins[15:0]};
			zext = {16'h0000, ins[15:0]};
			rd   = ins[15:11];
			rt   = ins[20:16];
			addr = rs_v + sext;
			case (ins[31:26])
				cpu_pkg::OP_RTYPE: begin
					case (ins[5:0])
						cpu_pkg::FN_SLL:  regs[rd] = rt_v << ins[10:6];
						cpu_pkg::FN_ADDU: regs[rd] = rs_v + rt_v;
						cpu_pkg::FN_SUBU: regs[rd] = rs_v - rt_v;
						cpu_pkg::FN_AND:  regs[rd] = rs_v & rt_v;
						cpu_pkg::FN_OR:   regs[rd] = rs_v | rt_v;
						cpu_pkg::FN_SLT:  regs[rd] = ($signed(rs_v) < $signed(rt_v)) ? 1 : 0;
						default: ;
					endcase
				end
				cpu_pkg::OP_ADDIU: regs[rt] = rs_v + sext;
				cpu_pkg::OP_SLTI:  regs[rt] = ($signed(rs_v) < $signed(sext)) ? 1 : 0;
				cpu_pkg::OP_ANDI:  regs[rt] = rs_v & zext;
				cpu_pkg::OP_ORI:   regs[rt] = rs_v | zext;
				cpu_pkg::OP_LUI:   regs[rt] = {ins[15:0], 16'h0000};
				cpu_pkg::OP_LW:    regs[rt] = mem[addr[9:2]];
				cpu_pkg::OP_SW: begin
					mem[addr[9:2]] = rt_v;
					exp_addr.push_back(addr);
					exp_data.push_back(rt_v);
				end
				cpu_pkg::OP_HALT: done = 1'b1;
				default: ;
			endcase
			regs[0] = '0;
			pc++;
		end
	endfunction

	always @(posedge CLK) begin
		if (!arst_n) begin
			armed     = 1'b0;
			halt_seen = 1'b0;
		end else begin
			// first cycle out of reset
			if (!armed) begin
				run_reference();
				armed     = 1'b1;
				store_idx = 0;
				check_cnt++;
				if (halt || dmemren || dmemwen || !imemren || imemaddr !== `CPU_PC_INIT) begin
					error_cnt++;
					$display("error at %0t: strobes or fetch address wrong after reset, pc %h",
						$time, imemaddr);
				end
			end
			if (dmemwen && dhit) begin
				if (store_idx >= exp_addr.size()) begin
					error_cnt++;
					$display("error at %0t: extra store of %h to %h, only %0d stores expected",
						$time, dmemstore, dmemaddr, exp_addr.size());
				end else begin
					check_cnt++;
					if (dmemaddr !== exp_addr[store_idx] || dmemstore !== exp_data[store_idx]) begin
						error_cnt++;
						$display("CHECK FAILED at %0t: store %0d expected %h at %h, got %h at %h",
							$time, store_idx, exp_data[store_idx], exp_addr[store_idx],
							dmemstore, dmemaddr);
					end
				end
				store_idx++;
			end
			if (halt && !halt_seen) begin
				halt_seen = 1'b1;
				check_cnt++;
				if (store_idx < exp_addr.size()) begin
					error_cnt++;
					$display("error at %0t: halt rose after %0d of %0d expected stores",
						$time, store_idx, exp_addr.size());
				end
			end
			// core must stay frozen until the next reset
			if (halt_seen) begin
				if (!halt) begin
					error_cnt++;
					$display("error at %0t: halt dropped before reset", $time);
				end
				if (imemren || dmemren || dmemwen) begin
					error_cnt++;
					$display("error at %0t: memory request raised while halted", $time);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/datapath_tb.sv ====
// ----------------------------
// testbench for the pipelined core, runs
// six programs with memory models and a checker
// ----------------------------

`default_nettype none

`include "cpu_macros.svh"

module datapath_tb;

	localparam int IMEM_WORDS = 512;
	localparam int DMEM_WORDS = 256;
	localparam int TEST_CNT   = 6;

	logic                   CLK    = 1'b0;
	logic                   arst_n = 1'b0;
	logic [`CPU_WORD_W-1:0] imemaddr;
	logic                   imemren;
	logic [`CPU_WORD_W-1:0] imemload;
	logic                   ihit   = 1'b1;
	logic [`CPU_WORD_W-1:0] dmemaddr;
	logic [`CPU_WORD_W-1:0] dmemstore;
	logic                   dmemren;
	logic                   dmemwen;
	logic [`CPU_WORD_W-1:0] dmemload;
	logic                   dhit   = 1'b1;
	logic                   halt;

	// program image, the checker reads it too
	logic [`CPU_WORD_W-1:0] prog [IMEM_WORDS];
	int                     prog_len;
	logic [`CPU_WORD_W-1:0] dmem [DMEM_WORDS];

	int          seed = 87;
	bit          rand_delay;
	int          iwait;
	int          dwait;
	int          draw;
	int          cur_test;
	int          cycle_cnt;
	int          cycle_limit;
	int          total_len;
	int          check_cnt;
	int          error_cnt;
	int          chk_before;
	int          err_before;
	int          tests_failed;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] op_c;

	always #50 CLK = ~CLK;

	datapath u_dut (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.imemaddr  (imemaddr),
		.imemren   (imemren),
		.imemload  (imemload),
		.ihit      (ihit),
		.dmemaddr  (dmemaddr),
		.dmemstore (dmemstore),
		.dmemren   (dmemren),
		.dmemwen   (dmemwen),
		.dmemload  (dmemload),
		.dhit      (dhit),
		.halt      (halt)
	);

	datapath_checker u_checker (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.imemaddr  (imemaddr),
		.imemren   (imemren),
		.dmemaddr  (dmemaddr),
		.dmemstore (dmemstore),
		.dmemren   (dmemren),
		.dmemwen   (dmemwen),
		.dhit      (dhit),
		.halt      (halt),
		.check_cnt (check_cnt),
		.error_cnt (error_cnt)
	);

	assign imemload = prog[imemaddr[10:2]];
	assign dmemload = dmem[dmemaddr[9:2]];

	function automatic int next_wait();
		return rand_delay ? int'($unsigned($random(seed)) % 4) : 0;
	endfunction

	// memories, hit strobes counted down per access
	always @(posedge CLK) begin
		if (!arst_n) begin
			ihit  <= 1'b1;
			dhit  <= 1'b1;
			iwait <= 0;
			dwait <= 0;
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else begin
			if (imemren) begin
				if (ihit) begin
					draw = next_wait();
					iwait <= draw;
					ihit  <= (draw == 0);
				end else begin
					iwait <= iwait - 1;
					ihit  <= (iwait == 1);
				end
			end
			if (dmemren || dmemwen) begin
				if (dhit) begin
					draw = next_wait();
					dwait <= draw;
					dhit  <= (draw == 0);
				end else begin
					dwait <= dwait - 1;
					dhit  <= (dwait == 1);
				end
			end
			if (dmemwen && dhit) begin
				dmem[dmemaddr[9:2]] <= dmemstore;
			end
		end
	end

	always @(posedge CLK) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout: test %0d (%s) hung, no halt within %0d cycles",
				cur_test, test_name(cur_test), cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic string test_name(int t);
		case (t)
			1:       return "r-type arithmetic";
			2:       return "immediate forms";
			3:       return "load/store round trip";
			4:       return "stall tolerance";
			5:       return "register zero";
			default: return "halt";
		endcase
	endfunction

	function automatic logic [31:0] rtype(cpu_pkg::funct_t fn, logic [4:0] rs, logic [4:0] rt,
			logic [4:0] rd, logic [4:0] sa);
		return {cpu_pkg::OP_RTYPE, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] itype(cpu_pkg::opcode_t op, logic [4:0] rs, logic [4:0] rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// three nop slots after each instruction cover the missing forwarding
	task automatic emit(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len += 4;
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		emit(itype(cpu_pkg::OP_LUI, 5'd0, rd, value[31:16]));
		emit(itype(cpu_pkg::OP_ORI, rd, rd, value[15:0]));
	endtask

	task automatic store_word(input logic [4:0] rt, input logic [4:0] base, input logic [15:0] off);
		emit(itype(cpu_pkg::OP_SW, base, rt, off));
	endtask

	task automatic build_program(input int t);
		for (int i = 0; i < IMEM_WORDS; i++) begin
			prog[i] = `CPU_NOP;
		end
		prog_len = 0;
		case (t)
			1, 4: begin
				load_const(1, op_a);
				load_const(2, op_b);
				load_const(3, op_c);
				emit(rtype(cpu_pkg::FN_ADDU, 1, 2, 4, 0));
				emit(rtype(cpu_pkg::FN_SUBU, 1, 2, 5, 0));
				emit(rtype(cpu_pkg::FN_AND, 1, 2, 6, 0));
				emit(rtype(cpu_pkg::FN_OR, 1, 2, 7, 0));
				emit(rtype(cpu_pkg::FN_SLT, 1, 2, 8, 0));
				emit(rtype(cpu_pkg::FN_SLT, 3, 1, 9, 0));
				emit(rtype(cpu_pkg::FN_SLT, 1, 3, 10, 0));
				emit(rtype(cpu_pkg::FN_SLL, 0, 2, 11, 7));
				emit(rtype(cpu_pkg::FN_SUBU, 3, 1, 12, 0));
				for (int r = 3; r <= 12; r++) begin
					store_word(r, 0, 16'(4 * (r - 3)));
				end
			end
			2: begin
				load_const(1, 32'h1234_5678);
				emit(itype(cpu_pkg::OP_ADDIU, 0, 2, 16'hfffb));
				emit(itype(cpu_pkg::OP_ADDIU, 1, 3, 16'h8001));
				emit(itype(cpu_pkg::OP_SLTI, 2, 4, 16'hfff0));
				emit(itype(cpu_pkg::OP_SLTI, 1, 5, 16'h8000));
				emit(itype(cpu_pkg::OP_SLTI, 2, 6, 16'h0003));
				emit(itype(cpu_pkg::OP_ANDI, 2, 7, 16'h8ff0));
				emit(itype(cpu_pkg::OP_ORI, 1, 8, 16'h8421));
				emit(itype(cpu_pkg::OP_ANDI, 1, 9, 16'hf0f0));
				emit(itype(cpu_pkg::OP_ORI, 0, 10, 16'hffff));
				for (int r = 2; r <= 10; r++) begin
					store_word(r, 0, 16'(16'h80 + 4 * (r - 2)));
				end
			end
			3: begin
				load_const(1, 32'h89ab_cdef);
				load_const(2, 32'h0123_4567);
				emit(itype(cpu_pkg::OP_ADDIU, 0, 10, 16'h0040));
				store_word(1, 10, 16'h0000);
				store_word(2, 10, 16'h0004);
				emit(itype(cpu_pkg::OP_LW, 10, 3, 16'h0000));
				emit(itype(cpu_pkg::OP_LW, 10, 4, 16'h0004));
				emit(rtype(cpu_pkg::FN_ADDU, 3, 4, 5, 0));
				emit(rtype(cpu_pkg::FN_SUBU, 3, 4, 6, 0));
				store_word(5, 10, 16'h0008);
				store_word(6, 10, 16'h000c);
				// negative offset lands below the base
				store_word(4, 10, 16'hfffc);
				emit(itype(cpu_pkg::OP_LW, 10, 7, 16'h0008));
				emit(rtype(cpu_pkg::FN_SLL, 0, 7, 8, 4));
				store_word(8, 10, 16'h0010);
			end
			5: begin
				load_const(1, 32'hcafe_f00d);
				emit(itype(cpu_pkg::OP_ADDIU, 0, 0, 16'h1234));
				emit(itype(cpu_pkg::OP_LUI, 0, 0, 16'habcd));
				emit(rtype(cpu_pkg::FN_ADDU, 1, 1, 0, 0));
				store_word(0, 0, 16'h0000);
				store_word(1, 0, 16'h0004);
				emit(itype(cpu_pkg::OP_LW, 0, 0, 16'h0004));
				store_word(0, 0, 16'h0008);
				emit(itype(cpu_pkg::OP_ORI, 0, 2, 16'h0000));
				store_word(2, 0, 16'h000c);
			end
			default: begin
				load_const(1, 32'h5a5a_0001);
				store_word(1, 0, 16'h0100);
				emit(itype(cpu_pkg::OP_ADDIU, 1, 2, 16'h0001));
				store_word(2, 0, 16'h0104);
				emit(itype(cpu_pkg::OP_HALT, 0, 0, 16'h0000));
				// never reach MEM
				store_word(1, 0, 16'h0108);
				store_word(2, 0, 16'h010c);
			end
		endcase
		emit(itype(cpu_pkg::OP_HALT, 0, 0, 16'h0000));
	endtask

	initial begin
		op_a = $random(seed) & 32'h7fff_ffff;
		op_b = $random(seed);
		op_c = $random(seed) | 32'h8000_0000;
		for (int t = 1; t <= TEST_CNT; t++) begin
			build_program(t);
			total_len += prog_len;
		end
		cycle_limit = 8 * total_len + 200;
		for (int t = 1; t <= TEST_CNT; t++) begin
			cur_test = t;
			@(posedge CLK);
			arst_n     <= 1'b0;
			rand_delay <= (t == 4);
			@(negedge CLK);
			build_program(t);
			repeat (4) @(posedge CLK);
			arst_n <= 1'b1;
			chk_before = check_cnt;
			err_before = error_cnt;
			@(posedge CLK);
			while (!halt) begin
				@(posedge CLK);
			end
			// a few cycles to watch the frozen core
			repeat (6) @(posedge CLK);
			@(negedge CLK);
			$display("test %0d %s: %0d checks, %0d errors", t, test_name(t),
				check_cnt - chk_before, error_cnt - err_before);
			if (error_cnt != err_before) begin
				tests_failed++;
			end
		end
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			TEST_CNT, tests_failed, check_cnt, error_cnt);
		if (tests_failed == 0 && error_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
// ----------------------------
// combinational integer alu for the
// EX stage, zero flag for later branches
// ----------------------------

`default_nettype none

`include "cpu_macros.svh"

module alu (
	input  logic [`CPU_WORD_W-1:0] a,
	input  logic [`CPU_WORD_W-1:0] b,
	input  logic [4:0]             shamt,
	input  cpu_pkg::alu_op_t       op,
	output logic [`CPU_WORD_W-1:0] result,
	output logic                   zero
);

	logic lt_signed;

	assign lt_signed = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD: result = a + b;
			cpu_pkg::ALU_SUB: result = a - b;
			cpu_pkg::ALU_AND: result = a & b;
			cpu_pkg::ALU_OR:  result = a | b;
			cpu_pkg::ALU_SLT: result = {{(`CPU_WORD_W-1){1'b0}}, lt_signed};
			// shifts the rt operand, as in sll rd,rt,sa
			cpu_pkg::ALU_SLL: result = b << shamt;
			// immediate moves to the upper half
			cpu_pkg::ALU_LUI: result = {b[15:0], 16'h0000};
			default:          result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== hdl/cpu_macros.svh ====
// ----------------------------
// core-wide widths and constants,
// included by any file that needs them
// ----------------------------

`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and address width
`define CPU_WORD_W 32

// architectural registers
`define CPU_REG_CNT 32

// fetch address after reset
`define CPU_PC_INIT 32'h0000_0000

// all-zero word, sll r0,r0,0
`define CPU_NOP 32'h0000_0000

`endif

// ==== hdl/cpu_pkg.sv ====
// ----------------------------
// instruction encodings, alu ops and the
// payloads carried by the stage latches
// ----------------------------

`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDIU = 6'h09,
		OP_SLTI  = 6'h0a,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b,
		OP_HALT  = 6'h3f
	} opcode_t;

	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} alu_op_t;

	typedef enum logic {
		WB_ALU = 1'b0,
		WB_MEM = 1'b1
	} wb_src_t;

	typedef struct packed {
		logic [`CPU_WORD_W-1:0] instr;
		logic                   valid;
	} if_id_t;

	typedef struct packed {
		alu_op_t                alu_op;
		logic                   use_imm;
		logic [`CPU_WORD_W-1:0] rdat1;
		logic [`CPU_WORD_W-1:0] rdat2;
		logic [`CPU_WORD_W-1:0] imm;
		logic [4:0]             shamt;
		logic [4:0]             dest;
		logic                   mem_ren;
		logic                   mem_wen;
		logic                   reg_wen;
		wb_src_t                wb_src;
		logic                   halt;
	} id_ex_t;

	typedef struct packed {
		logic [`CPU_WORD_W-1:0] alu_res;
		logic [`CPU_WORD_W-1:0] store;
		logic [4:0]             dest;
		logic                   mem_ren;
		logic                   mem_wen;
		logic                   reg_wen;
		wb_src_t                wb_src;
		logic                   halt;
	} ex_mem_t;

	// result already holds load data for a load
	typedef struct packed {
		logic [`CPU_WORD_W-1:0] result;
		logic [4:0]             dest;
		logic                   reg_wen;
		wb_src_t                wb_src;
	} mem_wb_t;

endpackage

`default_nettype wire

// ==== hdl/datapath.sv ====
// ----------------------------
// five-stage pipelined core, top level
// with instruction and data memory ports
// ----------------------------

`default_nettype none

`include "cpu_macros.svh"

module datapath (
	input  logic                   CLK,
	input  logic                   arst_n,
	// instruction side
	output logic [`CPU_WORD_W-1:0] imemaddr,
	output logic                   imemren,
	input  logic [`CPU_WORD_W-1:0] imemload,
	input  logic                   ihit,
	// data side
	output logic [`CPU_WORD_W-1:0] dmemaddr,
	output logic [`CPU_WORD_W-1:0] dmemstore,
	output logic                   dmemren,
	output logic                   dmemwen,
	input  logic [`CPU_WORD_W-1:0] dmemload,
	input  logic                   dhit,
	output logic                   halt
);

	cpu_pkg::if_id_t  if_id_d, if_id_q;
	cpu_pkg::id_ex_t  id_ex_d, id_ex_q;
	cpu_pkg::ex_mem_t ex_mem_d, ex_mem_q;
	cpu_pkg::mem_wb_t mem_wb_d, mem_wb_q;

	logic [`CPU_WORD_W-1:0] pc_q;
	logic                   halt_q;
	logic                   fetch_done;
	logic                   stall;
	logic                   advance;
	logic [`CPU_WORD_W-1:0] id_instr;
	logic [`CPU_WORD_W-1:0] alu_b;

	assign halt       = halt_q | ex_mem_q.halt;
	assign fetch_done = imemren & ihit;
	assign stall      = (dmemren | dmemwen) & ~dhit;
	// everything freezes once halt is seen in MEM
	assign advance    = ~stall & ~halt;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			pc_q   <= `CPU_PC_INIT;
			halt_q <= 1'b0;
		end else begin
			if (advance && fetch_done) begin
				pc_q <= pc_q + 4;
			end
			if (ex_mem_q.halt) begin
				halt_q <= 1'b1;
			end
		end
	end

	// IF
	assign imemaddr = pc_q;
	assign imemren  = ~halt;
	assign if_id_d  = '{instr: imemload, valid: 1'b1};

	stage_latch #(.payload_t(cpu_pkg::if_id_t)) u_if_id (
		.CLK    (CLK),
		.arst_n (arst_n),
		.en     (advance & fetch_done),
		.flush  (advance & ~fetch_done),
		.d      (if_id_d),
		.q      (if_id_q)
	);

	// ID
	assign id_instr = if_id_q.valid ? if_id_q.instr : `CPU_NOP;

	register_file u_register_file (
		.CLK    (CLK),
		.arst_n (arst_n),
		.rsel1  (id_instr[25:21]),
		.rsel2  (id_instr[20:16]),
		.wen    (mem_wb_q.reg_wen),
		.wsel   (mem_wb_q.dest),
		.wdat   (mem_wb_q.result),
		.rdat1  (id_ex_d.rdat1),
		.rdat2  (id_ex_d.rdat2)
	);

	decode_unit u_decode_unit (
		.instr   (id_instr),
		.alu_op  (id_ex_d.alu_op),
		.use_imm (id_ex_d.use_imm),
		.imm     (id_ex_d.imm),
		.shamt   (id_ex_d.shamt),
		.dest    (id_ex_d.dest),
		.reg_wen (id_ex_d.reg_wen),
		.mem_ren (id_ex_d.mem_ren),
		.mem_wen (id_ex_d.mem_wen),
		.wb_src  (id_ex_d.wb_src),
		.halt    (id_ex_d.halt)
	);

	stage_latch #(.payload_t(cpu_pkg::id_ex_t)) u_id_ex (
		.CLK    (CLK),
		.arst_n (arst_n),
		.en     (advance),
		.flush  (1'b0),
		.d      (id_ex_d),
		.q      (id_ex_q)
	);

	// EX
	assign alu_b = id_ex_q.use_imm ? id_ex_q.imm : id_ex_q.rdat2;

	alu u_alu (
		.a      (id_ex_q.rdat1),
		.b      (alu_b),
		.shamt  (id_ex_q.shamt),
		.op     (id_ex_q.alu_op),
		.result (ex_mem_d.alu_res),
		.zero   ()
	);

	always_comb begin
		ex_mem_d.store   = id_ex_q.rdat2;
		ex_mem_d.dest    = id_ex_q.dest;
		ex_mem_d.mem_ren = id_ex_q.mem_ren;
		ex_mem_d.mem_wen = id_ex_q.mem_wen;
		ex_mem_d.reg_wen = id_ex_q.reg_wen;
		ex_mem_d.wb_src  = id_ex_q.wb_src;
		ex_mem_d.halt    = id_ex_q.halt;
	end

	stage_latch #(.payload_t(cpu_pkg::ex_mem_t)) u_ex_mem (
		.CLK    (CLK),
		.arst_n (arst_n),
		.en     (advance),
		.flush  (1'b0),
		.d      (ex_mem_d),
		.q      (ex_mem_q)
	);

	// MEM
	assign dmemaddr  = ex_mem_q.alu_res;
	assign dmemstore = ex_mem_q.store;
	assign dmemren   = ex_mem_q.mem_ren & ~halt;
	assign dmemwen   = ex_mem_q.mem_wen & ~halt;

	// load data is captured on the dhit edge
	always_comb begin
		mem_wb_d.result  = (ex_mem_q.wb_src == cpu_pkg::WB_MEM) ? dmemload : ex_mem_q.alu_res;
		mem_wb_d.dest    = ex_mem_q.dest;
		mem_wb_d.reg_wen = ex_mem_q.reg_wen;
		mem_wb_d.wb_src  = ex_mem_q.wb_src;
	end

	stage_latch #(.payload_t(cpu_pkg::mem_wb_t)) u_mem_wb (
		.CLK    (CLK),
		.arst_n (arst_n),
		.en     (advance),
		.flush  (1'b0),
		.d      (mem_wb_d),
		.q      (mem_wb_q)
	);

	a_dmem_excl: assert property (@(posedge CLK) disable iff (!arst_n)
		!(dmemren && dmemwen));

	a_imem_aligned: assert property (@(posedge CLK) disable iff (!arst_n)
		imemaddr[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hdl/decode_unit.sv ====
// ----------------------------
// instruction decoder for the ID stage,
// produces control fields and the immediate
// ----------------------------

`default_nettype none

`include "cpu_macros.svh"

module decode_unit (
	input  logic [`CPU_WORD_W-1:0] instr,
	output cpu_pkg::alu_op_t       alu_op,
	output logic                   use_imm,
	output logic [`CPU_WORD_W-1:0] imm,
	output logic [4:0]             shamt,
	output logic [4:0]             dest,
	output logic                   reg_wen,
	output logic                   mem_ren,
	output logic                   mem_wen,
	output cpu_pkg::wb_src_t       wb_src,
	output logic                   halt
);

	logic [5:0] op_field;
	logic [5:0] fn_field;
	logic       zext;

	assign op_field = instr[31:26];
	assign fn_field = instr[5:0];
	assign shamt    = instr[10:6];

	// logical immediates are zero extended
	assign imm = zext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

	always_comb begin
		alu_op  = cpu_pkg::ALU_ADD;
		use_imm = 1'b0;
		zext    = 1'b0;
		dest    = instr[20:16];
		reg_wen = 1'b0;
		mem_ren = 1'b0;
		mem_wen = 1'b0;
		wb_src  = cpu_pkg::WB_ALU;
		halt    = 1'b0;
		case (op_field)
			cpu_pkg::OP_RTYPE: begin
				dest    = instr[15:11];
				reg_wen = 1'b1;
				case (fn_field)
					cpu_pkg::FN_SLL:  alu_op = cpu_pkg::ALU_SLL;
					cpu_pkg::FN_ADDU: alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::FN_SUBU: alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::FN_AND:  alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::FN_OR:   alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::FN_SLT:  alu_op = cpu_pkg::ALU_SLT;
					default:          reg_wen = 1'b0;
				endcase
			end
			cpu_pkg::OP_ADDIU: begin
				use_imm = 1'b1;
				reg_wen = 1'b1;
			end
			cpu_pkg::OP_SLTI: begin
				alu_op  = cpu_pkg::ALU_SLT;
				use_imm = 1'b1;
				reg_wen = 1'b1;
			end
			cpu_pkg::OP_ANDI: begin
				alu_op  = cpu_pkg::ALU_AND;
				use_imm = 1'b1;
				zext    = 1'b1;
				reg_wen = 1'b1;
			end
			cpu_pkg::OP_ORI: begin
				alu_op  = cpu_pkg::ALU_OR;
				use_imm = 1'b1;
				zext    = 1'b1;
				reg_wen = 1'b1;
			end
			cpu_pkg::OP_LUI: begin
				alu_op  = cpu_pkg::ALU_LUI;
				use_imm = 1'b1;
				reg_wen = 1'b1;
			end
			cpu_pkg::OP_LW: begin
				use_imm = 1'b1;
				reg_wen = 1'b1;
				mem_ren = 1'b1;
				wb_src  = cpu_pkg::WB_MEM;
			end
			cpu_pkg::OP_SW: begin
				use_imm = 1'b1;
				mem_wen = 1'b1;
			end
			cpu_pkg::OP_HALT: halt = 1'b1;
			// anything else falls through as a nop
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
// ----------------------------
// 32x32 register file, two reads and one
// write, r0 fixed at zero, write-through
// ----------------------------

`default_nettype none

`include "cpu_macros.svh"

module register_file (
	input  logic                   CLK,
	input  logic                   arst_n,
	input  logic [4:0]             rsel1,
	input  logic [4:0]             rsel2,
	input  logic                   wen,
	input  logic [4:0]             wsel,
	input  logic [`CPU_WORD_W-1:0] wdat,
	output logic [`CPU_WORD_W-1:0] rdat1,
	output logic [`CPU_WORD_W-1:0] rdat2
);

	logic [`CPU_WORD_W-1:0] regs [`CPU_REG_CNT];
	logic                   wr_live;

	// r0 never takes a write
	assign wr_live = wen && (wsel != 5'd0);

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CPU_REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[wsel] <= wdat;
		end
	end

	// bypass so decode sees this cycle's writeback
	assign rdat1 = (wr_live && (wsel == rsel1)) ? wdat : regs[rsel1];
	assign rdat2 = (wr_live && (wsel == rsel2)) ? wdat : regs[rsel2];

	a_r0_zero: assert property (@(posedge CLK) disable iff (!arst_n)
		((rsel1 == 5'd0) |-> (rdat1 == '0)) and ((rsel2 == 5'd0) |-> (rdat2 == '0)));

endmodule

`default_nettype wire

// ==== hdl/stage_latch.sv ====
// ----------------------------
// pipeline register for any stage payload,
// holds when idle, bubble on flush
// ----------------------------

`default_nettype none

module stage_latch #(
	parameter type payload_t = logic
) (
	input  logic     CLK,
	input  logic     arst_n,
	input  logic     en,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// an all-zero payload is a bubble
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (flush) begin
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

	a_en_flush_excl: assert property (@(posedge CLK) disable iff (!arst_n)
		!(en && flush));

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/register_file.sv
hdl/decode_unit.sv
hdl/alu.sv
hdl/stage_latch.sv
hdl/datapath.sv
dv/datapath_checker.sv
dv/datapath_tb.sv
